// ==== build.f ====
hw/pipe_ctrl_pkg.sv
hw/mem_bus_pkg.sv
hw/pipeline_control.sv
hw/fetch_port.sv
hw/load_store_port.sv
hw/mem_arbiter.sv
hw/shared_ram.sv
hw/core_frontend_top.sv
bench/tb_core_frontend.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the core frontend testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -j 0 \
  -f build.f \
  --top-module tb_core_frontend \
  -o sim_tb

./obj_dir/sim_tb | tee sim.log

if grep -q "Test failures found" sim.log; then
  echo "simulation FAILED, see sim.log"
  exit 1
fi

echo "simulation passed, see sim.log"
exit 0

// ==== bench/tb_core_frontend.sv ====
module tb_core_frontend;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int RAM_LAT = 2;
  localparam int TMO     = 50; // cycles per wait

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 load_use_i, jump_i, muldiv_i, trap_stall_i, trap_flush_i;
  logic [31:0]          jump_target_i;
  logic                 ls_req_i;
  mem_bus_pkg::mem_op_e ls_op_i;
  logic [31:0]          ls_addr_i, ls_wdata_i;
  logic [5:0]           stall_o, flush_o;
  logic                 instr_valid_o, fetch_busy_o, mem_busy_o, ls_done_o;
  logic [31:0]          instr_o, pc_o, ls_rdata_o;

  logic [31:0] mem_model [256]; // mirror of stored words
  logic [11:0] exp_ctrl;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  core_frontend_top #(
    .RAM_DEPTH_WORDS(256), .RAM_LATENCY(RAM_LAT), .RESET_PC(32'h0)
  ) UUT (
    .clk(clk), .rst(rst), .load_use_i(load_use_i), .jump_i(jump_i),
    .jump_target_i(jump_target_i), .muldiv_i(muldiv_i), .trap_stall_i(trap_stall_i),
    .trap_flush_i(trap_flush_i), .ls_req_i(ls_req_i), .ls_op_i(ls_op_i),
    .ls_addr_i(ls_addr_i), .ls_wdata_i(ls_wdata_i), .stall_o(stall_o), .flush_o(flush_o),
    .instr_valid_o(instr_valid_o), .instr_o(instr_o), .pc_o(pc_o),
    .fetch_busy_o(fetch_busy_o), .mem_busy_o(mem_busy_o), .ls_rdata_o(ls_rdata_o),
    .ls_done_o(ls_done_o)
  );

  always #5 clk = ~clk; // 10 ns period

  // priority list, highest first, result is {stall, flush}
  function automatic logic [11:0] expected_ctrl(input logic rst_v, input logic valid_v,
      input logic if_wait_v, input logic mem_wait_v, input logic lu_v, input logic jmp_v,
      input logic md_v, input logic ts_v, input logic tf_v);
    logic [5:0] s;
    logic [5:0] f;
    s = 6'b000000;
    f = 6'b000000;
    if (rst_v) begin
      f = 6'b011111;
    end else if (mem_wait_v) begin
      s = 6'b001111;
      f = 6'b100000;
    end else if (if_wait_v) begin
      s = 6'b001111; // fetch wait, nothing flushed
    end else if (tf_v) begin
      s = 6'b000010;
      f = 6'b001110;
    end else if (ts_v) begin
      s = 6'b111111;
      f = 6'b001110;
    end else if (jmp_v && !valid_v) begin
      s = 6'b000111;
      f = 6'b001000;
    end else if (jmp_v) begin
      s = 6'b000010;
      f = 6'b000110;
    end else if (md_v) begin
      s = 6'b000111;
      f = 6'b010000;
    end else if (lu_v) begin
      s = 6'b000011;
      f = 6'b001000;
    end else if (!valid_v) begin
      s = 6'b000111; // bubble
      f = 6'b001000;
    end
    return {s, f};
  endfunction

  // controller is combinational, compare mid-cycle when inputs have settled
  always @(negedge clk) begin
    exp_ctrl = expected_ctrl(rst, instr_valid_o, fetch_busy_o, mem_busy_o, load_use_i,
                             jump_i, muldiv_i, trap_stall_i, trap_flush_i);
    if (stall_o !== exp_ctrl[11:6]) begin
      $display("error: stall_o expected %h got %h at %0t", exp_ctrl[11:6], stall_o, $time);
      errors++;
    end
    if (flush_o !== exp_ctrl[5:0]) begin
      $display("error: flush_o expected %h got %h at %0t", exp_ctrl[5:0], flush_o, $time);
      errors++;
    end
  end

  task automatic finish_test(input string name, input int errs_at_start);
    tests_run++;
    if (errors == errs_at_start) begin
      $display("test %s: ok", name);
    end else begin
      tests_failed++;
      $display("test %s: FAILED with %0d errors", name, errors - errs_at_start);
    end
  endtask

  // next instr_valid_o pulse, pc and word captured mid-cycle
  task automatic wait_instr(output logic [31:0] pc, output logic [31:0] instr);
    int n;
    n = 0;
    pc = 32'h0;
    instr = 32'h0;
    do begin
      @(negedge clk);
      n++;
      if (!instr_valid_o && fetch_busy_o !== 1'b1) begin
        $display("error: fetch_busy_o while fetching expected %h got %h", 1'b1, fetch_busy_o);
        errors++;
      end
    end while (!instr_valid_o && n < TMO);
    if (instr_valid_o) begin
      pc = pc_o;
      instr = instr_o;
      if (fetch_busy_o !== 1'b0) begin
        $display("error: fetch_busy_o with data expected %h got %h", 1'b0, fetch_busy_o);
        errors++;
      end
    end else begin
      $display("timeout: no instr_valid_o pulse within %0d cycles", TMO);
      errors++;
    end
  endtask

  // one load/store, started right after a fetch ends so the arbiter is idle
  task automatic ls_access(input mem_bus_pkg::mem_op_e op, input logic [31:0] addr,
      input logic [31:0] wdata, output logic [31:0] rdata);
    int n;
    n = 0;
    rdata = 32'h0;
    do begin
      @(negedge clk);
      n++;
    end while (fetch_busy_o && n < TMO); // low in the fetch done cycle
    if (fetch_busy_o) begin
      $display("timeout: fetch never finished before the access");
      errors++;
    end
    @(posedge clk);
    #1;
    ls_req_i = 1'b1;
    ls_op_i = op;
    ls_addr_i = addr;
    ls_wdata_i = wdata;
    n = 0;
    do begin
      @(negedge clk);
      if (!ls_done_o) begin
        n++;
        if (n == 1 && mem_busy_o !== 1'b1) begin
          $display("error: mem_busy_o while pending expected %h got %h", 1'b1, mem_busy_o);
          errors++;
        end
      end
    end while (!ls_done_o && n < TMO);
    if (!ls_done_o) begin
      $display("timeout: ls_done_o did not rise within %0d cycles", TMO);
      errors++;
    end else begin
      rdata = ls_rdata_o;
      if (n != RAM_LAT + 1) begin
        $display("error: ls_done_o latency expected %h got %h", RAM_LAT + 1, n);
        errors++;
      end
      if (mem_busy_o !== 1'b0) begin
        $display("error: mem_busy_o at done expected %h got %h", 1'b0, mem_busy_o);
        errors++;
      end
    end
    @(posedge clk);
    #1;
    ls_req_i = 1'b0; // dropped the cycle after done
  endtask

  initial begin
    int          e0;
    int          n;
    logic [31:0] addrs [8];
    logic [31:0] pcs [10];
    logic [31:0] rd, wd, a, pc, instr;
    void'($urandom(8271));
    rst = 1'b1;
    load_use_i = 1'b0;
    jump_i = 1'b0;
    jump_target_i = 32'h0;
    muldiv_i = 1'b0;
    trap_stall_i = 1'b0;
    trap_flush_i = 1'b0;
    ls_req_i = 1'b0;
    ls_op_i = mem_bus_pkg::MEM_LOAD;
    ls_addr_i = 32'h0;
    ls_wdata_i = 32'h0;
    for (int i = 0; i < 256; i++) mem_model[i] = 32'h0; // ram powers up cleared

    // reset values, then quiet outputs until the first fetch returns
    e0 = errors;
    repeat (2) begin
      @(negedge clk);
      if (stall_o !== 6'h00) begin
        $display("error: stall_o in reset expected %h got %h", 6'h00, stall_o);
        errors++;
      end
      if (flush_o !== 6'h1f) begin
        $display("error: flush_o in reset expected %h got %h", 6'h1f, flush_o);
        errors++;
      end
    end
    @(posedge clk);
    #1;
    rst = 1'b0;
    n = 0;
    do begin
      @(negedge clk);
      n++;
      if (n == 1 && instr_valid_o !== 1'b0) begin
        $display("error: instr_valid_o after reset expected %h got %h", 1'b0, instr_valid_o);
        errors++;
      end
      if (ls_done_o !== 1'b0) begin
        $display("error: ls_done_o after reset expected %h got %h", 1'b0, ls_done_o);
        errors++;
      end
    end while (!instr_valid_o && n < TMO);
    if (!instr_valid_o) begin
      $display("timeout: first fetch never completed");
      errors++;
    end
    finish_test("reset", e0);

    // random hazard strobes, checker does the comparing
    e0 = errors;
    repeat (400) begin
      @(posedge clk);
      #1;
      load_use_i = ($urandom % 4) == 0;
      jump_i = ($urandom % 8) == 0;
      jump_target_i = ($urandom % 256) << 2;
      muldiv_i = ($urandom % 8) == 0;
      trap_stall_i = ($urandom % 16) == 0;
      trap_flush_i = ($urandom % 16) == 0;
    end
    @(posedge clk);
    #1;
    {load_use_i, jump_i, muldiv_i, trap_stall_i, trap_flush_i} = 5'b0;
    finish_test("random hazards", e0);

    // stores then loads back from the same words
    e0 = errors;
    for (int i = 0; i < 8; i++) begin
      addrs[i] = ($urandom % 256) << 2;
      wd = $urandom;
      ls_access(mem_bus_pkg::MEM_STORE, addrs[i], wd, rd);
      mem_model[addrs[i][9:2]] = wd;
    end
    for (int i = 0; i < 8; i++) begin
      ls_access(mem_bus_pkg::MEM_LOAD, addrs[i], 32'h0, rd);
      if (rd !== mem_model[addrs[i][9:2]]) begin
        $display("error: ls_rdata_o expected %h got %h", mem_model[addrs[i][9:2]], rd);
        errors++;
      end
    end
    finish_test("load store", e0);

    // sequential fetch with hazards quiet
    e0 = errors;
    for (int i = 0; i < 10; i++) begin
      wait_instr(pcs[i], instr);
      if (i > 0 && pcs[i] !== pcs[i-1] + 32'd4) begin
        $display("error: pc_o expected %h got %h", pcs[i-1] + 32'd4, pcs[i]);
        errors++;
      end
    end
    finish_test("sequential pc", e0);

    // jump to a freshly stored word
    e0 = errors;
    a = ($urandom % 256) << 2;
    wd = $urandom;
    ls_access(mem_bus_pkg::MEM_STORE, a, wd, rd);
    mem_model[a[9:2]] = wd;
    @(posedge clk);
    #1;
    jump_i = 1'b1;
    jump_target_i = a;
    n = 0;
    do begin
      @(negedge clk);
      n++;
    end while (!instr_valid_o && n < TMO); // redirect happens with fetch data present
    if (!instr_valid_o) begin
      $display("timeout: jump was never taken");
      errors++;
    end
    @(posedge clk);
    #1;
    jump_i = 1'b0;
    wait_instr(pc, instr);
    if (pc !== a) begin
      $display("error: pc_o after jump expected %h got %h", a, pc);
      errors++;
    end
    if (instr !== wd) begin
      $display("error: instr_o after jump expected %h got %h", wd, instr);
      errors++;
    end
    wait_instr(pc, instr);
    if (pc !== a + 32'd4) begin
      $display("error: pc_o after target expected %h got %h", a + 32'd4, pc);
      errors++;
    end
    finish_test("jump", e0);

    $display("tests run %0d, tests failed %0d, check errors %0d",
             tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("All tests passed!");
    end else begin
      $display("Test failures found");
    end
    $finish;
  end

endmodule

// ==== hw/core_frontend_top.sv ====
module core_frontend_top #(
  parameter int                             RAM_DEPTH_WORDS = 256,
  parameter int                             RAM_LATENCY     = 2,
  parameter logic [mem_bus_pkg::ADDR_W-1:0] RESET_PC        = '0
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic                                 load_use_i,
  input  logic                                 jump_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0]       jump_target_i,
  input  logic                                 muldiv_i,
  input  logic                                 trap_stall_i,
  input  logic                                 trap_flush_i,
  input  logic                                 ls_req_i,
  input  mem_bus_pkg::mem_op_e                 ls_op_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0]       ls_addr_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]       ls_wdata_i,
  output logic [pipe_ctrl_pkg::NUM_STAGES-1:0] stall_o,
  output logic [pipe_ctrl_pkg::NUM_STAGES-1:0] flush_o,
  output logic                                 instr_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0]       instr_o,
  output logic [mem_bus_pkg::ADDR_W-1:0]       pc_o,
  output logic                                 fetch_busy_o,
  output logic                                 mem_busy_o,
  output logic [mem_bus_pkg::DATA_W-1:0]       ls_rdata_o,
  output logic                                 ls_done_o
);

  logic                           fetch_req, fetch_done;
  logic [mem_bus_pkg::ADDR_W-1:0] fetch_addr;
  logic                           data_req, data_done;
  mem_bus_pkg::mem_op_e           data_op;
  logic [mem_bus_pkg::ADDR_W-1:0] data_addr, ram_addr;
  logic [mem_bus_pkg::DATA_W-1:0] data_wdata, arb_rdata, ram_wdata, ram_rdata;
  logic                           ram_en, ram_we, ram_done;

  pipeline_control u_ctrl (
    .rst(rst), .if_rdata_valid_i(instr_valid_o), .ram_stall_valid_if_i(fetch_busy_o),
    .ram_stall_valid_mem_i(mem_busy_o), .load_use_valid_id_i(load_use_i),
    .jump_valid_ex_i(jump_i), .alu_mul_div_valid_ex_i(muldiv_i),
    .trap_stall_valid_wb_i(trap_stall_i), .trap_flush_valid_wb_i(trap_flush_i),
    .stall_o(stall_o), .flush_o(flush_o)
  );

  fetch_port #(.RESET_PC(RESET_PC)) u_fetch (
    .clk(clk), .rst(rst), .stall_i(stall_o), .flush_i(flush_o), .jump_i(jump_i),
    .jump_target_i(jump_target_i), .fetch_req_o(fetch_req), .fetch_addr_o(fetch_addr),
    .fetch_done_i(fetch_done), .fetch_rdata_i(arb_rdata), .fetch_wait_o(fetch_busy_o),
    .instr_valid_o(instr_valid_o), .instr_o(instr_o), .pc_o(pc_o)
  );

  load_store_port u_ls (
    .clk(clk), .rst(rst), .ls_req_i(ls_req_i), .ls_op_i(ls_op_i), .ls_addr_i(ls_addr_i),
    .ls_wdata_i(ls_wdata_i), .data_req_o(data_req), .data_op_o(data_op),
    .data_addr_o(data_addr), .data_wdata_o(data_wdata), .data_done_i(data_done),
    .data_rdata_i(arb_rdata), .mem_wait_o(mem_busy_o), .ls_rdata_o(ls_rdata_o),
    .ls_done_o(ls_done_o)
  );

  mem_arbiter u_arb (
    .clk(clk), .rst(rst), .fetch_req_i(fetch_req), .fetch_addr_i(fetch_addr),
    .data_req_i(data_req), .data_op_i(data_op), .data_addr_i(data_addr),
    .data_wdata_i(data_wdata), .fetch_done_o(fetch_done), .data_done_o(data_done),
    .rdata_o(arb_rdata), .ram_en_o(ram_en), .ram_we_o(ram_we), .ram_addr_o(ram_addr),
    .ram_wdata_o(ram_wdata), .ram_done_i(ram_done), .ram_rdata_i(ram_rdata)
  );

  shared_ram #(.RAM_DEPTH_WORDS(RAM_DEPTH_WORDS), .RAM_LATENCY(RAM_LATENCY)) u_ram (
    .clk(clk), .rst(rst), .en_i(ram_en), .we_i(ram_we), .addr_i(ram_addr),
    .wdata_i(ram_wdata), .done_o(ram_done), .rdata_o(ram_rdata)
  );

endmodule

// ==== hw/shared_ram.sv ====
module shared_ram #(
  parameter int RAM_DEPTH_WORDS = 256,
  parameter int RAM_LATENCY     = 2 // 1 to 4
) (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           en_i,
  input  logic                           we_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0] addr_i, // byte address, low two bits ignored
  input  logic [mem_bus_pkg::DATA_W-1:0] wdata_i,
  output logic                           done_o,
  output logic [mem_bus_pkg::DATA_W-1:0] rdata_o
);

  localparam int IDX_W = $clog2(RAM_DEPTH_WORDS);

  logic [mem_bus_pkg::DATA_W-1:0] mem_q [RAM_DEPTH_WORDS];
  logic [mem_bus_pkg::DATA_W-1:0] rdata_q;
  logic [2:0]                     cnt_q; // cycles left, 0 when idle
  logic [IDX_W-1:0]               idx;

  assign idx = addr_i[IDX_W+1:2];

  initial begin
    for (int i = 0; i < RAM_DEPTH_WORDS; i++) begin
      mem_q[i] = '0;
    end
  end

  // write and read both happen at acceptance
  always_ff @(posedge clk) begin
    if (en_i) begin
      if (we_i) begin
        mem_q[idx] <= wdata_i;
      end
      rdata_q <= mem_q[idx]; // old word on a store
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      cnt_q <= '0;
    end else if (en_i) begin
      cnt_q <= 3'(RAM_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 3'd1;
    end
  end

  assign done_o  = (cnt_q == 3'd1); // RAM_LATENCY cycles after en
  assign rdata_o = rdata_q;

endmodule

// ==== hw/mem_arbiter.sv ====
module mem_arbiter (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           fetch_req_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0] fetch_addr_i,
  input  logic                           data_req_i,
  input  mem_bus_pkg::mem_op_e           data_op_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0] data_addr_i,
  input  logic [mem_bus_pkg::DATA_W-1:0] data_wdata_i,
  output logic                           fetch_done_o,
  output logic                           data_done_o,
  output logic [mem_bus_pkg::DATA_W-1:0] rdata_o,
  output logic                           ram_en_o,
  output logic                           ram_we_o,
  output logic [mem_bus_pkg::ADDR_W-1:0] ram_addr_o,
  output logic [mem_bus_pkg::DATA_W-1:0] ram_wdata_o,
  input  logic                           ram_done_i,
  input  logic [mem_bus_pkg::DATA_W-1:0] ram_rdata_i
);

  mem_bus_pkg::arb_state_e state_q, state_d;

  // grant in idle, access presented the same cycle
  always_comb begin
    state_d     = state_q;
    ram_en_o    = 1'b0;
    ram_we_o    = 1'b0;
    ram_addr_o  = fetch_addr_i;
    ram_wdata_o = data_wdata_i;
    case (state_q)
      mem_bus_pkg::ARB_IDLE: begin
        if (data_req_i) begin // data first
          ram_en_o   = 1'b1;
          ram_we_o   = (data_op_i == mem_bus_pkg::MEM_STORE);
          ram_addr_o = data_addr_i;
          state_d    = mem_bus_pkg::ARB_DATA;
        end else if (fetch_req_i) begin
          ram_en_o = 1'b1;
          state_d  = mem_bus_pkg::ARB_FETCH;
        end
      end
      mem_bus_pkg::ARB_FETCH,
      mem_bus_pkg::ARB_DATA: begin
        if (ram_done_i) begin
          state_d = mem_bus_pkg::ARB_IDLE; // free again next cycle
        end
      end
      default: state_d = mem_bus_pkg::ARB_IDLE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= mem_bus_pkg::ARB_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // done goes back to whoever owns the port
  assign fetch_done_o = ram_done_i & (state_q == mem_bus_pkg::ARB_FETCH);
  assign data_done_o  = ram_done_i & (state_q == mem_bus_pkg::ARB_DATA);
  assign rdata_o      = ram_rdata_i; // shared return bus

endmodule

// ==== hw/load_store_port.sv ====
module load_store_port (
  input  logic                           clk,
  input  logic                           rst,
  input  logic                           ls_req_i,   // held by mem stage until ls_done_o
  input  mem_bus_pkg::mem_op_e           ls_op_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0] ls_addr_i,
  input  logic [mem_bus_pkg::DATA_W-1:0] ls_wdata_i,
  output logic                           data_req_o,
  output mem_bus_pkg::mem_op_e           data_op_o,
  output logic [mem_bus_pkg::ADDR_W-1:0] data_addr_o,
  output logic [mem_bus_pkg::DATA_W-1:0] data_wdata_o,
  input  logic                           data_done_i,
  input  logic [mem_bus_pkg::DATA_W-1:0] data_rdata_i,
  output logic                           mem_wait_o,
  output logic [mem_bus_pkg::DATA_W-1:0] ls_rdata_o,
  output logic                           ls_done_o
);

  logic                           done_q;
  logic [mem_bus_pkg::DATA_W-1:0] rdata_q;

  // forwarded the same cycle so an idle arbiter grants at once
  // masked in the done cycle, mem stage still holds its request there
  assign data_req_o   = ls_req_i & ~done_q;
  assign data_op_o    = ls_op_i;
  assign data_addr_o  = ls_addr_i;
  assign data_wdata_o = ls_wdata_i;

  // holds the mem stage until the ram answers
  assign mem_wait_o = data_req_o & ~data_done_i;

  assign ls_done_o  = done_q;
  assign ls_rdata_o = rdata_q;

  always_ff @(posedge clk) begin
    if (rst) begin
      done_q <= 1'b0;
    end else begin
      done_q <= data_done_i; // one cycle pulse
    end
  end

  // load data only, stores leave the last value
  always_ff @(posedge clk) begin
    if (data_done_i && ls_op_i == mem_bus_pkg::MEM_LOAD) begin
      rdata_q <= data_rdata_i;
    end
  end

endmodule

// ==== hw/fetch_port.sv ====
module fetch_port #(
  parameter logic [mem_bus_pkg::ADDR_W-1:0] RESET_PC = '0
) (
  input  logic                                 clk,
  input  logic                                 rst,
  input  logic [pipe_ctrl_pkg::NUM_STAGES-1:0] stall_i,
  input  logic [pipe_ctrl_pkg::NUM_STAGES-1:0] flush_i,
  input  logic                                 jump_i,
  input  logic [mem_bus_pkg::ADDR_W-1:0]       jump_target_i,
  output logic                                 fetch_req_o,
  output logic [mem_bus_pkg::ADDR_W-1:0]       fetch_addr_o,
  input  logic                                 fetch_done_i,
  input  logic [mem_bus_pkg::DATA_W-1:0]       fetch_rdata_i,
  output logic                                 fetch_wait_o,
  output logic                                 instr_valid_o,
  output logic [mem_bus_pkg::DATA_W-1:0]       instr_o,
  output logic [mem_bus_pkg::ADDR_W-1:0]       pc_o
);

  logic [mem_bus_pkg::ADDR_W-1:0] pc_q;  // address of the fetch in flight
  logic                           run_q; // fetching enabled, low only in reset
  logic                           discard_q; // fetch in flight is stale
  logic                           pc_hold;
  logic                           jump_take;
  logic                           kill_if;

  assign pc_hold   = stall_i[pipe_ctrl_pkg::STAGE_PC];
  assign jump_take = jump_i & ~pc_hold;
  assign kill_if   = flush_i[pipe_ctrl_pkg::STAGE_PRE_IF] | flush_i[pipe_ctrl_pkg::STAGE_IF_ID];

  // request level stays up, arbiter regrants after each done
  assign fetch_req_o  = run_q;
  assign fetch_addr_o = pc_q;
  assign fetch_wait_o = run_q & ~fetch_done_i; // starving until data shows up

  // data goes straight out in the done cycle
  assign instr_valid_o = fetch_done_i & ~discard_q;
  assign instr_o       = fetch_rdata_i;
  assign pc_o          = pc_q; // pc still points at the returning word

  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q      <= RESET_PC;
      run_q     <= 1'b0;
      discard_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (jump_take) begin
        pc_q <= jump_target_i; // redirect wins over sequential
      end else if (instr_valid_o && !pc_hold) begin
        pc_q <= pc_q + 32'd4;
      end
      // stale-fetch marker, dropped when that fetch returns
      if (fetch_done_i) begin
        discard_q <= 1'b0;
      end else if (run_q && (jump_take || kill_if)) begin
        discard_q <= 1'b1;
      end
    end
  end

endmodule

// ==== hw/pipeline_control.sv ====
module pipeline_control (
  input  logic                                 rst,
  input  logic                                 if_rdata_valid_i,      // fetch data arrived
  input  logic                                 ram_stall_valid_if_i,  // fetch waiting on ram
  input  logic                                 ram_stall_valid_mem_i, // load/store waiting
  input  logic                                 load_use_valid_id_i,
  input  logic                                 jump_valid_ex_i,
  input  logic                                 alu_mul_div_valid_ex_i,
  input  logic                                 trap_stall_valid_wb_i,
  input  logic                                 trap_flush_valid_wb_i,
  output logic [pipe_ctrl_pkg::NUM_STAGES-1:0] stall_o,
  output logic [pipe_ctrl_pkg::NUM_STAGES-1:0] flush_o
);

  pipe_ctrl_pkg::hazard_cause_e cause;

  // later stages win, memory waits above everything
  always_comb begin
    if (ram_stall_valid_mem_i) begin
      cause = pipe_ctrl_pkg::CAUSE_RAM_MEM;
    end else if (ram_stall_valid_if_i) begin
      cause = pipe_ctrl_pkg::CAUSE_RAM_IF;
    end else if (trap_flush_valid_wb_i) begin
      cause = pipe_ctrl_pkg::CAUSE_TRAP_FLUSH; // ecall style redirect
    end else if (trap_stall_valid_wb_i) begin
      cause = pipe_ctrl_pkg::CAUSE_TRAP_STALL; // csr access
    end else if (jump_valid_ex_i && !if_rdata_valid_i) begin
      cause = pipe_ctrl_pkg::CAUSE_JUMP_BUBBLE; // wait for fetch before redirect
    end else if (jump_valid_ex_i) begin
      cause = pipe_ctrl_pkg::CAUSE_JUMP;
    end else if (alu_mul_div_valid_ex_i) begin
      cause = pipe_ctrl_pkg::CAUSE_MULDIV;
    end else if (load_use_valid_id_i) begin
      cause = pipe_ctrl_pkg::CAUSE_LOAD_USE;
    end else if (!if_rdata_valid_i) begin
      cause = pipe_ctrl_pkg::CAUSE_FETCH_BUBBLE;
    end else begin
      cause = pipe_ctrl_pkg::CAUSE_NONE;
    end
  end

  // cause to preset pair, reset overrides
  always_comb begin
    stall_o = '0;
    flush_o = '0;
    if (rst) begin
      flush_o = pipe_ctrl_pkg::RESET_FLUSH; // stall stays clear
    end else begin
      case (cause)
        pipe_ctrl_pkg::CAUSE_RAM_MEM: begin
          stall_o = pipe_ctrl_pkg::RAM_MEM_STALL;
          flush_o = pipe_ctrl_pkg::RAM_MEM_FLUSH;
        end
        pipe_ctrl_pkg::CAUSE_RAM_IF: begin
          stall_o = pipe_ctrl_pkg::RAM_MEM_STALL; // same hold as a data wait
          flush_o = pipe_ctrl_pkg::RAM_IF_FLUSH;
        end
        pipe_ctrl_pkg::CAUSE_TRAP_FLUSH: begin
          stall_o = pipe_ctrl_pkg::TRAP_ECALL_STALL;
          flush_o = pipe_ctrl_pkg::TRAP_ECALL_FLUSH;
        end
        pipe_ctrl_pkg::CAUSE_TRAP_STALL: begin
          stall_o = pipe_ctrl_pkg::TRAP_CSR_STALL;
          flush_o = pipe_ctrl_pkg::TRAP_CSR_FLUSH;
        end
        pipe_ctrl_pkg::CAUSE_JUMP: begin
          stall_o = pipe_ctrl_pkg::JUMP_STALL;
          flush_o = pipe_ctrl_pkg::JUMP_FLUSH;
        end
        pipe_ctrl_pkg::CAUSE_MULDIV: begin
          stall_o = pipe_ctrl_pkg::MULDIV_STALL;
          flush_o = pipe_ctrl_pkg::MULDIV_FLUSH;
        end
        pipe_ctrl_pkg::CAUSE_LOAD_USE: begin
          stall_o = pipe_ctrl_pkg::LOAD_USE_STALL;
          flush_o = pipe_ctrl_pkg::LOAD_USE_FLUSH;
        end
        pipe_ctrl_pkg::CAUSE_JUMP_BUBBLE,
        pipe_ctrl_pkg::CAUSE_FETCH_BUBBLE: begin
          stall_o = pipe_ctrl_pkg::BUBBLE_STALL;
          flush_o = pipe_ctrl_pkg::BUBBLE_FLUSH;
        end
        default: begin
          stall_o = '0; // CAUSE_NONE, free running
          flush_o = '0;
        end
      endcase
    end
  end

endmodule

// ==== hw/mem_bus_pkg.sv ====
package mem_bus_pkg;

  localparam int ADDR_W = 32; // byte address
  localparam int DATA_W = 32; // one word per access

  // who owns the single ram port
  typedef enum logic [1:0] {
    ARB_IDLE,
    ARB_FETCH,
    ARB_DATA
  } arb_state_e;

  typedef enum logic {
    MEM_LOAD,
    MEM_STORE
  } mem_op_e;

endpackage

// ==== hw/pipe_ctrl_pkg.sv ====
package pipe_ctrl_pkg;

  // one bit per pipeline boundary, same order in stall and flush
  localparam int STAGE_PC     = 0;
  localparam int STAGE_PRE_IF = 1;
  localparam int STAGE_IF_ID  = 2;
  localparam int STAGE_ID_EX  = 3;
  localparam int STAGE_EX_MEM = 4;
  localparam int STAGE_MEM_WB = 5;

  localparam int NUM_STAGES = 6;

  localparam logic [NUM_STAGES-1:0] LOAD_USE_STALL   = 6'b000011; // hold pc, pre_if
  localparam logic [NUM_STAGES-1:0] LOAD_USE_FLUSH   = 6'b001000; // bubble into id_ex
  localparam logic [NUM_STAGES-1:0] JUMP_STALL       = 6'b000010;
  localparam logic [NUM_STAGES-1:0] JUMP_FLUSH       = 6'b000110; // wrong-path fetch + decode
  localparam logic [NUM_STAGES-1:0] MULDIV_STALL     = 6'b000111;
  localparam logic [NUM_STAGES-1:0] MULDIV_FLUSH     = 6'b010000; // bubble into ex_mem
  localparam logic [NUM_STAGES-1:0] TRAP_CSR_STALL   = 6'b111111; // freeze everything
  localparam logic [NUM_STAGES-1:0] TRAP_CSR_FLUSH   = 6'b001110;
  localparam logic [NUM_STAGES-1:0] TRAP_ECALL_STALL = 6'b000010;
  localparam logic [NUM_STAGES-1:0] TRAP_ECALL_FLUSH = 6'b001110;
  localparam logic [NUM_STAGES-1:0] RAM_MEM_STALL    = 6'b001111; // everything up to id_ex
  localparam logic [NUM_STAGES-1:0] RAM_MEM_FLUSH    = 6'b100000; // no writeback while waiting
  localparam logic [NUM_STAGES-1:0] RAM_IF_FLUSH     = 6'b000000; // fetch wait flushes nothing

  // fetch data missing, hold the front and feed a bubble
  localparam logic [NUM_STAGES-1:0] BUBBLE_STALL     = 6'b000111;
  localparam logic [NUM_STAGES-1:0] BUBBLE_FLUSH     = 6'b001000;

  localparam logic [NUM_STAGES-1:0] RESET_FLUSH      = 6'b011111;

  // winner of the priority chain
  typedef enum logic [3:0] {
    CAUSE_NONE,
    CAUSE_RAM_MEM,
    CAUSE_RAM_IF,
    CAUSE_TRAP_FLUSH,
    CAUSE_TRAP_STALL,
    CAUSE_JUMP_BUBBLE,
    CAUSE_JUMP,
    CAUSE_MULDIV,
    CAUSE_LOAD_USE,
    CAUSE_FETCH_BUBBLE
  } hazard_cause_e;

endpackage
